/* common/game_pkg.sv */
package game_pkg;

  // --------------------------------------------------
  // course layout
  // --------------------------------------------------
  localparam int course_len = 33;   // boxes in one round
  localparam int window_len = 8;    // boxes visible on the leds at once

  // bit 0 is the box in front of the player, 1 = right, 0 = left
  localparam logic [course_len-1:0] course_map = 33'h0D15D9689;

  // --------------------------------------------------
  // scores and timer digits
  // --------------------------------------------------
  typedef logic [3:0] bcd_t;         // one decimal digit

  typedef struct packed {
    bcd_t tens;                      // upper digit, msb side so compares work
    bcd_t ones;
  } score_t;

  localparam score_t score_start = '{tens: 4'd3, ones: 4'd2};  // both sides start at 32

  // side lamps for the box the player has to hit next
  typedef struct packed {
    logic left;
    logic right;
  } cue_t;

  // --------------------------------------------------
  // cpu pace
  // --------------------------------------------------
  typedef enum logic [1:0] {
    speed_easy,                      // 1.5 steps per second
    speed_medium,                    // 2 steps per second
    speed_hard,                      // 3 steps per second
    speed_extreme                    // 5 steps per second
  } speed_t;

  localparam int tick_w = 28;        // wide enough for 50 MHz dividers

  // clocks between two cpu steps at the given board clock
  function automatic logic [tick_w-1:0] cpu_period(input int clk_hz, input speed_t speed);
    int clocks;
    case (speed)
      speed_easy:    clocks = clk_hz * 2 / 3;
      speed_medium:  clocks = clk_hz / 2;
      speed_hard:    clocks = clk_hz / 3;
      speed_extreme: clocks = clk_hz / 5;
      default:       clocks = clk_hz * 2 / 3;
    endcase
    return tick_w'(clocks);
  endfunction

endpackage

/* common/display_pkg.sv */
package display_pkg;

  typedef logic [6:0] seg_t;         // active low, g down to a

  // the eight digits of the board, msb field first
  typedef struct packed {
    seg_t time_ones;
    seg_t time_tens;
    seg_t best_ones;
    seg_t best_tens;
    seg_t cpu_ones;
    seg_t cpu_tens;
    seg_t player_ones;
    seg_t player_tens;
  } seg_bank_t;

  // glyphs for 0..9, index is the bcd value
  localparam seg_t seg_table [10] = '{
    7'b100_0000,                     // 0
    7'b111_1001,                     // 1
    7'b010_0100,                     // 2
    7'b011_0000,                     // 3
    7'b001_1001,                     // 4
    7'b001_0010,                     // 5
    7'b000_0010,                     // 6
    7'b111_1000,                     // 7
    7'b000_0000,                     // 8
    7'b001_0000                      // 9
  };

endpackage

/* course/box_course.sv */
`timescale 1ns/1ns

module box_course (
  input  logic           clk,
  input  logic           reset,
  input  logic           new_game,     // reload the course for a fresh round
  input  logic           step,         // one pulse per correct switch
  output logic           next_box,     // side of the box in front of the player
  output logic [7:0]     course_leds,  // upcoming boxes, led 0 is next
  output game_pkg::cue_t cue           // lamp for the side to flip
);

  import game_pkg::*;

  logic [course_len-1:0] boxes;        // remaining course, bit 0 first

  // --------------------------------------------------
  // course shift register
  // --------------------------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      boxes <= course_map;             // full course after power up
    end else if (new_game) begin
      boxes <= course_map;             // restart from the first box
    end else if (step) begin
      boxes <= {1'b0, boxes[course_len-1:1]};  // drop the box just taken, pad with left
    end
  end

  // --------------------------------------------------
  // outputs
  // --------------------------------------------------
  assign next_box    = boxes[0];                 // box to be judged
  assign course_leds = boxes[window_len-1:0];    // window onto the next boxes

  // exactly one lamp lit at any time
  assign cue.right = boxes[0];
  assign cue.left  = ~boxes[0];

endmodule

/* logic/key_judge.sv */
`timescale 1ns/1ns

module key_judge (
  input  logic clk,
  input  logic reset,
  input  logic run,       // judging only while the game runs
  input  logic left,      // left slide switch
  input  logic right,     // right slide switch
  input  logic next_box,  // 1 = right box, 0 = left box
  output logic step       // one clock per new correct switch
);

  logic match;            // switches agree with the box right now
  logic match_q;          // match from the previous clock

  // right switch on a right box, or left switch on a left box
  assign match = run & ((right & next_box) | (left & ~next_box));

  // --------------------------------------------------
  // rising edge of the match, registered
  // --------------------------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      match_q <= 1'b0;
      step    <= 1'b0;
    end else begin
      match_q <= match;
      step    <= match & ~match_q;  // held switch gives no second step
    end
  end

  // a switch held across two boxes of the same side keeps match high,
  // so the player has to release and flip again to advance

endmodule

/* score/cpu_pacer.sv */
`timescale 1ns/1ns

module cpu_pacer #(
  parameter int clk_hz = 50_000_000        // board clock in hz
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             run,            // count only while the game runs
  input  logic             new_game,       // restart the divider for a new round
  input  game_pkg::speed_t speed,          // selected cpu pace
  output logic             cpu_tick        // one clock per cpu step
);

  import game_pkg::*;

  logic [tick_w-1:0] count;                // clocks left until the next tick
  logic [tick_w-1:0] reload;               // last count for the current speed
  logic              running;              // divider enabled

  assign reload  = cpu_period(clk_hz, speed) - 1'b1;  // count runs period-1 down to 0
  assign running = run & ~new_game;

  // --------------------------------------------------
  // reloading down counter
  // --------------------------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      count <= reload;
    end else if (new_game) begin
      count <= reload;                     // fresh period, picks up the speed switch
    end else if (running) begin
      if (count == '0) begin
        count <= reload;                   // new speed only takes effect here
      end else begin
        count <= count - 1'b1;
      end
    end
  end

  // terminal count, only while the divider is live
  assign cpu_tick = running & (count == '0);

endmodule

/* score/bcd_countdown.sv */
`timescale 1ns/1ns

module bcd_countdown (
  input  logic             clk,
  input  logic             reset,
  input  logic             new_game,   // back to 32 for a new round
  input  logic             dec,        // one step for this side
  input  logic             finished,   // either side is done, freeze
  output game_pkg::score_t score,      // boxes still to go
  output logic             done        // this side has crossed the line
);

  import game_pkg::*;

  // --------------------------------------------------
  // two digit bcd countdown
  // --------------------------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      score <= score_start;
      done  <= 1'b0;
    end else if (new_game) begin
      score <= score_start;
      done  <= 1'b0;
    end else if (dec && !finished) begin
      if (score == '0) begin
        done <= 1'b1;                      // step taken at 00 ends the race
      end else if (score.ones == 4'd0) begin
        score.ones <= 4'd9;                // borrow from the tens
        score.tens <= score.tens - 1'b1;
      end else begin
        score.ones <= score.ones - 1'b1;
      end
    end
  end

  // score stays at 00 once done, finished blocks any further dec

endmodule

/* logic/race_clock.sv */
`timescale 1ns/1ns

module race_clock #(
  parameter int clk_hz = 50_000_000      // board clock in hz
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             new_game,     // clears the round time
  input  logic             run,          // time only runs during play
  input  logic             finished,     // either side done, stop the clock
  input  logic             player_done,  // player crossed the line
  output game_pkg::score_t elapsed,      // seconds into the round
  output game_pkg::score_t best          // fastest player win so far
);

  import game_pkg::*;

  logic [tick_w-1:0] sec_count;          // clocks left in this second
  logic              sec_run;            // divider enabled
  logic              sec_tick;           // one clock per second
  logic              done_q;             // player_done one clock late
  logic              player_win;         // first clock of the player finish

  assign sec_run  = run & ~finished & ~new_game;
  assign sec_tick = sec_run & (sec_count == '0);

  // --------------------------------------------------
  // seconds divider
  // --------------------------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      sec_count <= tick_w'(clk_hz - 1);
    end else if (new_game) begin
      sec_count <= tick_w'(clk_hz - 1);
    end else if (sec_run) begin
      if (sec_count == '0) begin
        sec_count <= tick_w'(clk_hz - 1);  // next second
      end else begin
        sec_count <= sec_count - 1'b1;
      end
    end
  end

  // --------------------------------------------------
  // bcd seconds, 00 to 99 then wraps
  // --------------------------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      elapsed <= '0;
    end else if (new_game) begin
      elapsed <= '0;
    end else if (sec_tick) begin
      if (elapsed.ones == 4'd9) begin
        elapsed.ones <= 4'd0;            // carry into the tens
        elapsed.tens <= (elapsed.tens == 4'd9) ? 4'd0 : elapsed.tens + 1'b1;
      end else begin
        elapsed.ones <= elapsed.ones + 1'b1;
      end
    end
  end

  // --------------------------------------------------
  // best time, kept across rounds
  // --------------------------------------------------
  assign player_win = player_done & ~done_q;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      done_q <= 1'b0;
      best   <= '0;                      // 00 means no win yet
    end else begin
      done_q <= player_done;
      // packed bcd with tens on top compares like a plain number
      if (player_win && (best == '0 || elapsed < best)) begin
        best <= elapsed;
      end
    end
  end

endmodule

/* logic/seg_display.sv */
`timescale 1ns/1ns

module seg_display (
  input  game_pkg::score_t        elapsed,       // round time
  input  game_pkg::score_t        best,          // best winning time
  input  game_pkg::score_t        cpu_score,     // cpu boxes left
  input  game_pkg::score_t        player_score,  // player boxes left
  output display_pkg::seg_bank_t  hex            // all eight digits
);

  import display_pkg::*;

  // glyph for one digit, codes above 9 fall back to 0
  function automatic seg_t digit_seg(input logic [3:0] digit);
    return (digit <= 4'd9) ? seg_table[digit] : seg_table[0];
  endfunction

  // --------------------------------------------------
  // digit placement
  // --------------------------------------------------
  always_comb begin
    hex.time_ones   = digit_seg(elapsed.ones);
    hex.time_tens   = digit_seg(elapsed.tens);
    hex.best_ones   = digit_seg(best.ones);
    hex.best_tens   = digit_seg(best.tens);
    hex.cpu_ones    = digit_seg(cpu_score.ones);
    hex.cpu_tens    = digit_seg(cpu_score.tens);
    hex.player_ones = digit_seg(player_score.ones);
    hex.player_tens = digit_seg(player_score.tens);
  end

endmodule

/* logic/pyonpyon_top.sv */
`timescale 1ns/1ns

module pyonpyon_top #(
  parameter int clk_hz = 50_000_000           // board clock in hz
) (
  input  logic                   clk,
  input  logic                   reset,         // clears everything incl best time
  input  logic                   run,           // game advances while high
  input  logic                   new_game,      // hold round at start values
  input  game_pkg::speed_t       speed,         // cpu pace
  input  logic                   left,          // left slide switch
  input  logic                   right,         // right slide switch
  output display_pkg::seg_bank_t hex,           // seven segment bank
  output logic [7:0]             course_leds,   // next boxes
  output game_pkg::cue_t         cue,           // side to flip next
  output logic                   player_done,
  output logic                   cpu_done
);

  import game_pkg::*;

  logic   next_box;                             // side of the box in front
  logic   step;                                 // correct switch pulse
  logic   course_step;                          // step that still moves the course
  logic   cpu_tick;                             // cpu step pulse
  logic   finished;                             // race over for both sides
  score_t player_score;
  score_t cpu_score;
  score_t elapsed;
  score_t best;

  assign finished    = player_done | cpu_done;  // first side home ends the race
  assign course_step = step & ~finished;        // course frozen after the finish

  // --------------------------------------------------
  // player side
  // --------------------------------------------------
  key_judge judge (
    .clk      (clk),
    .reset    (reset),
    .run      (run),
    .left     (left),
    .right    (right),
    .next_box (next_box),
    .step     (step)
  );

  box_course course (
    .clk         (clk),
    .reset       (reset),
    .new_game    (new_game),
    .step        (course_step),
    .next_box    (next_box),
    .course_leds (course_leds),
    .cue         (cue)
  );

  bcd_countdown player_count (
    .clk      (clk),
    .reset    (reset),
    .new_game (new_game),
    .dec      (step),
    .finished (finished),
    .score    (player_score),
    .done     (player_done)
  );

  // --------------------------------------------------
  // cpu side
  // --------------------------------------------------
  cpu_pacer #(.clk_hz(clk_hz)) pacer (
    .clk      (clk),
    .reset    (reset),
    .run      (run),
    .new_game (new_game),
    .speed    (speed),
    .cpu_tick (cpu_tick)
  );

  bcd_countdown cpu_count (
    .clk      (clk),
    .reset    (reset),
    .new_game (new_game),
    .dec      (cpu_tick),
    .finished (finished),
    .score    (cpu_score),
    .done     (cpu_done)
  );

  // --------------------------------------------------
  // timer and display
  // --------------------------------------------------
  race_clock #(.clk_hz(clk_hz)) timer (
    .clk         (clk),
    .reset       (reset),
    .new_game    (new_game),
    .run         (run),
    .finished    (finished),
    .player_done (player_done),
    .elapsed     (elapsed),
    .best        (best)
  );

  seg_display display (
    .elapsed      (elapsed),
    .best         (best),
    .cpu_score    (cpu_score),
    .player_score (player_score),
    .hex          (hex)
  );

endmodule

/* sim/pyonpyon_tb.sv */
`timescale 1ns/1ns

module pyonpyon_tb;

  import game_pkg::*;
  import display_pkg::*;

  localparam int clk_hz     = 60;        // tiny board clock, short periods
  localparam int done_limit = 200;       // cycles allowed for a done flag

  logic       clk;
  logic       reset;
  logic       run;
  logic       new_game;
  speed_t     speed;
  logic       left;
  logic       right;
  seg_bank_t  hex;
  logic [7:0] course_leds;
  cue_t       cue;
  logic       player_done;
  logic       cpu_done;

  // expected state, updated after each rising edge, compared on the falling edge
  logic [course_len-1:0] model_course;   // remaining boxes, bit 0 next
  int        exp_player;
  int        exp_cpu;
  int        exp_elapsed;
  int        exp_best;
  logic      exp_player_done;
  logic      exp_cpu_done;
  seg_bank_t exp_hex;

  int   k;                               // rising edges since run went high
  int   p;                               // cpu period in clocks
  int   stop_k;                          // edge of the first finish
  int   step_at;                         // edge where a pending step lands
  int   win_k;                           // edge of the player finish
  logic counting;                        // round in progress
  logic compare_on;
  int   seed = 96391;
  int   tests_run;
  int   tests_failed;
  int   checks;
  int   errors;
  int   test_errs;

  pyonpyon_top #(.clk_hz(clk_hz)) dut0 (
    .clk         (clk),
    .reset       (reset),
    .run         (run),
    .new_game    (new_game),
    .speed       (speed),
    .left        (left),
    .right       (right),
    .hex         (hex),
    .course_leds (course_leds),
    .cue         (cue),
    .player_done (player_done),
    .cpu_done    (cpu_done)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;              // 40 ns period
  end

  // --------------------------------------------------
  // reference functions
  // --------------------------------------------------
  function automatic int pace_clocks(input speed_t s);
    case (s)
      speed_easy:   return clk_hz * 2 / 3;
      speed_medium: return clk_hz / 2;
      speed_hard:   return clk_hz / 3;
      default:      return clk_hz / 5;
    endcase
  endfunction

  // ones glyph first, the order used in the bank
  function automatic logic [13:0] score_glyphs(input int value);
    return {seg_table[4'(value % 10)], seg_table[4'(value / 10)]};
  endfunction

  function automatic seg_bank_t bank_of(input int t, input int b, input int c, input int pl);
    return {score_glyphs(t), score_glyphs(b), score_glyphs(c), score_glyphs(pl)};
  endfunction

  // lower time wins, 0 means no win yet
  function automatic int best_after(input int best, input int finish);
    return (best == 0 || finish < best) ? finish : best;
  endfunction

  function automatic cue_t cue_of(input logic box);
    cue_t c;
    c.left  = ~box;
    c.right = box;
    return c;
  endfunction

  // --------------------------------------------------
  // model upkeep and stimulus
  // --------------------------------------------------
  task automatic reset_model(input speed_t pace);
    k               = 0;
    p               = pace_clocks(pace);
    stop_k          = 33 * p;            // cpu home after 33 ticks
    step_at         = -1;
    win_k           = -1;
    model_course    = course_map;
    exp_player      = 32;
    exp_cpu         = 32;
    exp_elapsed     = 0;
    exp_player_done = 1'b0;
    exp_cpu_done    = 1'b0;
  endtask

  task automatic advance_model();
    int kk;
    int ticks;
    if (counting) begin
      k = k + 1;
      if (k == step_at) begin
        step_at      = -1;
        model_course = model_course >> 1;      // box taken
        if (exp_player == 0) begin
          exp_player_done = 1'b1;              // step at 00 crosses the line
          win_k           = k;
          if (k < stop_k) begin
            stop_k = k;
          end
        end else begin
          exp_player = exp_player - 1;
        end
      end
      if (win_k >= 0 && k == win_k + 1) begin
        exp_best = best_after(exp_best, exp_elapsed);  // one edge after the win
      end
      kk           = (k < stop_k) ? k : stop_k;  // everything freezes at the finish
      ticks        = kk / p;
      exp_cpu      = (ticks > 32) ? 0 : 32 - ticks;
      exp_cpu_done = (ticks > 32);
      exp_elapsed  = (kk / clk_hz) % 100;
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    advance_model();
    @(negedge clk);
  endtask

  // a fresh flip on the side of the next box earns one step
  task automatic flip_on(input logic go_right);
    if (counting && go_right == model_course[0] && stop_k > k + 1) begin
      step_at = k + 2;                   // judged next edge, counted the edge after
    end
    if (go_right) begin
      right = 1'b1;
    end else begin
      left = 1'b1;
    end
  endtask

  task automatic press(input logic go_right, input int gap);
    flip_on(go_right);
    repeat (2) next_cycle();
    left  = 1'b0;
    right = 1'b0;
    repeat (gap + 1) next_cycle();
  endtask

  task automatic wait_for_done(input string name, input logic cpu_side, input int limit);
    int n;
    n = 0;
    while ((cpu_side ? cpu_done : player_done) !== 1'b1 && n < limit) begin
      next_cycle();
      n = n + 1;
    end
    if ((cpu_side ? cpu_done : player_done) !== 1'b1) begin
      $display("timeout: %s done flag did not rise within %0d cycles", name, limit);
      $display("Testbench failed");
      $finish;
    end
  endtask

  task automatic new_round(input speed_t pace);
    run      = 1'b0;
    new_game = 1'b1;
    left     = 1'b0;
    right    = 1'b0;
    speed    = pace;
    counting = 1'b0;
    @(posedge clk);
    reset_model(pace);                   // best survives
    @(negedge clk);
    next_cycle();
    new_game = 1'b0;
    run      = 1'b1;
    counting = 1'b1;
  endtask

  task automatic run_player_round(input int gap);
    repeat (course_len) press(model_course[0], gap);
    wait_for_done("player", 1'b0, done_limit);
    repeat (3) next_cycle();             // best loads after the finish
  endtask

  task automatic finish_test(input string name);
    @(posedge clk);
    advance_model();
    tests_run = tests_run + 1;
    if (errors == test_errs) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed = tests_failed + 1;
      $display("test %0d %s: %0d errors", tests_run, name, errors - test_errs);
    end
    test_errs = errors;
    @(negedge clk);
  endtask

  // --------------------------------------------------
  // compare process
  // --------------------------------------------------
  always @(negedge clk) begin
    if (compare_on) begin
      exp_hex = bank_of(exp_elapsed, exp_best, exp_cpu, exp_player);
      checks  = checks + 1;
      assert (hex === exp_hex) else begin
        errors = errors + 1;
        $display("ERROR hex expected %h actual %h", exp_hex, hex);
      end
      assert (course_leds === model_course[7:0]) else begin
        errors = errors + 1;
        $display("ERROR course_leds expected %h actual %h", model_course[7:0], course_leds);
      end
      assert (cue === cue_of(model_course[0])) else begin
        errors = errors + 1;
        $display("ERROR cue expected %h actual %h", cue_of(model_course[0]), cue);
      end
      assert (player_done === exp_player_done) else begin
        errors = errors + 1;
        $display("ERROR player_done expected %h actual %h", exp_player_done, player_done);
      end
      assert (cpu_done === exp_cpu_done) else begin
        errors = errors + 1;
        $display("ERROR cpu_done expected %h actual %h", exp_cpu_done, cpu_done);
      end
    end
  end

  // --------------------------------------------------
  // test sequence
  // --------------------------------------------------
  initial begin
    int pick;
    reset        = 1'b1;
    run          = 1'b0;
    new_game     = 1'b0;
    speed        = speed_easy;
    left         = 1'b0;
    right        = 1'b0;
    counting     = 1'b0;
    compare_on   = 1'b0;
    exp_best     = 0;
    tests_run    = 0;
    tests_failed = 0;
    checks       = 0;
    errors       = 0;
    test_errs    = 0;
    reset_model(speed_easy);
    repeat (8) @(negedge clk);
    reset = 1'b0;
    @(posedge clk);
    compare_on = 1'b1;
    @(negedge clk);

    repeat (3) next_cycle();             // idle, run low
    finish_test("start values");

    run      = 1'b1;                     // round straight out of reset
    counting = 1'b1;
    press(~model_course[0], 2);          // wrong side
    press(model_course[0], 2);
    flip_on(model_course[0]);            // box 1 and box 2 share a side
    repeat (6) next_cycle();             // held, no second step
    left  = 1'b0;
    right = 1'b0;
    next_cycle();
    press(model_course[0], 2);           // fresh flip takes box 2
    finish_test("key judging");

    pick = $random(seed);
    new_round(speed_t'(pick[1:0]));
    $display("cpu pace %0d clocks per step", p);
    repeat (33 * p) next_cycle();
    wait_for_done("cpu", 1'b1, done_limit);
    finish_test("cpu pace");

    repeat (70) next_cycle();            // more than a second, time holds
    press(model_course[0], 2);           // too late to move
    finish_test("timer");

    new_round(speed_easy);
    run_player_round(7);
    new_round(speed_easy);
    run_player_round(1);                 // faster round
    new_round(speed_easy);
    run_player_round(12);                // slower round
    new_round(speed_easy);
    repeat (5) next_cycle();
    finish_test("player win and best time");

    $display("tests %0d, failed tests %0d, compare cycles %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* sim.f */
common/game_pkg.sv
common/display_pkg.sv
course/box_course.sv
logic/key_judge.sv
score/cpu_pacer.sv
score/bcd_countdown.sv
logic/race_clock.sv
logic/seg_display.sv
logic/pyonpyon_top.sv
sim/pyonpyon_tb.sv

/* Makefile */
SRCS := $(shell cat sim.f)

.PHONY: run clean

run: obj_dir/Vpyonpyon_tb
	@out=$$(./obj_dir/Vpyonpyon_tb); echo "$$out"; echo "$$out" | grep -q "Testbench passed"

obj_dir/V%: $(SRCS) sim.f
	verilator --binary --timing --assert -f sim.f --top-module $*

clean:
	rm -rf obj_dir
